// ==== alarmBank.sv ====
module alarmBank (
  input  logic                              clk_1x,
  input  logic                              reset,
  input  atsPkg::alarmWriteT [1:0]          alarmWr,
  input  atsPkg::countArrayT                counts,
  input  logic [atsPkg::numClocks-1:0]      tick,
  output logic [atsPkg::numAlarms-1:0]      data
);

  logic [atsPkg::numAlarms-1:0] enable;
  logic [atsPkg::numAlarms-1:0] loop;       // repeat after firing
  logic [3:0]                   clockSel [atsPkg::numAlarms];
  atsPkg::countT                value    [atsPkg::numAlarms];
  logic [1:0]                   fireCnt  [atsPkg::numAlarms];  // cycles of data left
  logic [atsPkg::numAlarms-1:0] match;
  logic [atsPkg::numAlarms-1:0] wrHit;      // slot written this cycle

  ////////////////////////////////////////////////////////////////////////////
  // match detection
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int k = 0; k < atsPkg::numAlarms; k++) begin
      wrHit[k] = 1'b0;
      for (int w = 0; w < 2; w++) begin
        if (alarmWr[w].valid && (alarmWr[w].sel == k)) wrHit[k] = 1'b1;
      end
      // fires on the edge where the count steps onto the value
      match[k] = enable[k] && tick[clockSel[k]] &&
                 (atsPkg::countT'(counts[clockSel[k]] + 1'b1) == value[k]);
    end
  end

  // enables, loop bits, firing counters
  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      enable <= '0;
      loop   <= '0;
      for (int k = 0; k < atsPkg::numAlarms; k++) begin
        fireCnt[k] <= 2'd0;
      end
    end else begin
      for (int k = 0; k < atsPkg::numAlarms; k++) begin
        if (match[k] && !wrHit[k]) begin    // a write drops the match
          fireCnt[k] <= 2'd2;
          if (!loop[k]) enable[k] <= 1'b0;  // one-shot disarms itself
        end else if (fireCnt[k] != 2'd0) begin
          fireCnt[k] <= fireCnt[k] - 2'd1;
        end
      end
      for (int w = 0; w < 2; w++) begin
        if (alarmWr[w].valid) begin
          enable[alarmWr[w].sel] <= alarmWr[w].enable;
          if (alarmWr[w].load) loop[alarmWr[w].sel] <= alarmWr[w].loop;
        end
      end
    end
  end

  // slot programming, only read while enabled
  always_ff @(posedge clk_1x) begin
    for (int w = 0; w < 2; w++) begin
      if (alarmWr[w].valid && alarmWr[w].load) begin
        clockSel[alarmWr[w].sel] <= alarmWr[w].clockSel;
        value[alarmWr[w].sel]    <= alarmWr[w].value;
      end
    end
  end

  always_comb begin
    for (int k = 0; k < atsPkg::numAlarms; k++) begin
      data[k] = (fireCnt[k] != 2'd0);   // two cycles per firing
    end
  end

endmodule

// ==== atsPkg.sv ====
package atsPkg;

  ////////////////////////////////////////////////////////////////////////////
  // sizes fixed by the instruction format
  ////////////////////////////////////////////////////////////////////////////

  localparam int numClocks  = 16;         // programmable counters
  localparam int numAlarms  = 24;         // alarm / timer slots, also data width
  localparam int countWidth = 16;         // counter width

  typedef logic [countWidth-1:0] countT;
  typedef countT [numClocks-1:0] countArrayT;   // all counter values

  // rate codes, 11 is parked and never advances
  localparam logic [1:0] rate1x      = 2'b00;
  localparam logic [1:0] rateHalf    = 2'b01;
  localparam logic [1:0] rateQuarter = 2'b10;

  // opcode sits in bits 31:29 of the joined instruction
  typedef enum logic [2:0] {
    opNop      = 3'b000,
    opSetClock = 3'b001,
    opEnClock  = 3'b010,
    opMode     = 3'b011,  // no longer supported, refused
    opSetAlarm = 3'b101,
    opSetTimer = 3'b110,
    opEnAlarm  = 3'b111
  } opcodeT;

  typedef struct packed {
    opcodeT     opcode;   // 31:29
    logic [4:0] target;   // alarm number, or clock number in 4:1
    logic       flag;     // 23: enable / repeat / upper rate bit
    logic       rateLo;   // 22
    logic [1:0] spare;
    logic [3:0] clockSel; // 19:16, clock an alarm or timer runs against
    countT      value;    // count, alarm value or interval
  } instrT;

  ////////////////////////////////////////////////////////////////////////////
  // write commands from the arbiter to the banks
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic       valid;
    logic [3:0] sel;      // counter number
    logic       load;     // count, rate and enable, not just enable
    logic       enable;
    logic [1:0] rate;
    countT      count;
  } clockWriteT;

  typedef struct packed {
    logic       valid;
    logic [4:0] sel;      // slot number
    logic       load;     // full reprogram
    logic       enable;
    logic       loop;     // repeat after firing
    logic [3:0] clockSel;
    countT      value;    // match value, deadline for timers
  } alarmWriteT;

endpackage

// ==== clockBank.sv ====
module clockBank (
  input  logic                              clk_1x,
  input  logic                              reset,
  input  atsPkg::clockWriteT [1:0]          clockWr,
  output atsPkg::countArrayT                counts,
  output logic [atsPkg::numClocks-1:0]      tick
);

  logic [atsPkg::numClocks-1:0] enable;
  logic [1:0]                   rate [atsPkg::numClocks];
  logic [1:0]                   div;       // free-running prescaler
  logic [atsPkg::numClocks-1:0] loadHit;   // counter reloaded this cycle
  logic                         due;

  ////////////////////////////////////////////////////////////////////////////
  // rate enables and tick vector
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < atsPkg::numClocks; i++) begin
      loadHit[i] = 1'b0;
      for (int w = 0; w < 2; w++) begin
        if (clockWr[w].valid && clockWr[w].load && (clockWr[w].sel == i)) begin
          loadHit[i] = 1'b1;
        end
      end
      case (rate[i])
        atsPkg::rate1x:      due = 1'b1;
        atsPkg::rateHalf:    due = div[0];
        atsPkg::rateQuarter: due = (div == 2'b11);
        default:             due = 1'b0;          // code 11 is parked
      endcase
      tick[i] = enable[i] && due && !loadHit[i];  // a reload is not an advance
    end
  end

  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      div    <= 2'b00;
      enable <= '0;
      counts <= '0;
      for (int i = 0; i < atsPkg::numClocks; i++) begin
        rate[i] <= atsPkg::rate1x;
      end
    end else begin
      div <= div + 2'd1;
      for (int i = 0; i < atsPkg::numClocks; i++) begin
        if (tick[i]) counts[i] <= counts[i] + 1'b1;   // wraps
      end
      // writes land after the increments, so they win
      for (int w = 0; w < 2; w++) begin
        if (clockWr[w].valid) begin
          enable[clockWr[w].sel] <= clockWr[w].enable;
          if (clockWr[w].load) begin
            counts[clockWr[w].sel] <= clockWr[w].count;
            rate[clockWr[w].sel]   <= clockWr[w].rate;
          end
        end
      end
    end
  end

endmodule

// ==== cmdArbiter.sv ====
module cmdArbiter (
  input  logic                          clk_1x,
  input  logic                          reset,
  input  atsPkg::instrT                 instrA,
  input  atsPkg::instrT                 instrB,
  input  logic                          validA,
  input  logic                          validB,
  input  atsPkg::countArrayT            counts,
  output atsPkg::clockWriteT [1:0]      clockWr,
  output atsPkg::alarmWriteT [1:0]      alarmWr,
  output logic [1:0]                    stat
);

  atsPkg::instrT            side [2];   // index 0 is client A
  logic [1:0]               valid;
  logic [1:0]               isClk;      // legal clock class instruction
  logic [1:0]               isAlm;      // legal alarm / timer class instruction
  logic [1:0]               accept;
  logic                     clash;      // both sides on the same target
  atsPkg::clockWriteT [1:0] clkNext;
  atsPkg::alarmWriteT [1:0] almNext;

  assign valid   = {validB, validA};
  assign side[0] = instrA;
  assign side[1] = instrB;

  ////////////////////////////////////////////////////////////////////////////
  // decode and conflict check
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int s = 0; s < 2; s++) begin
      // invalid side behaves as a nop
      isClk[s] = valid[s] &&
                 (side[s].opcode inside {atsPkg::opSetClock, atsPkg::opEnClock});
      // slots 24..31 do not exist, refused
      isAlm[s] = valid[s] &&
                 (side[s].opcode inside {atsPkg::opSetAlarm, atsPkg::opSetTimer,
                                         atsPkg::opEnAlarm}) &&
                 (side[s].target < atsPkg::numAlarms);
    end

    // alarm and timer opcodes share one class, so they clash with each other
    clash = (isClk[0] && isClk[1] && (side[0].target[4:1] == side[1].target[4:1])) ||
            (isAlm[0] && isAlm[1] && (side[0].target == side[1].target));

    accept = (isClk | isAlm) & ~{2{clash}};   // nop, mode, junk stay 0
  end

  ////////////////////////////////////////////////////////////////////////////
  // write commands
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int s = 0; s < 2; s++) begin
      clkNext[s]        = '0;
      clkNext[s].valid  = accept[s] && isClk[s];
      clkNext[s].sel    = side[s].target[4:1];          // clock number in upper four
      clkNext[s].load   = (side[s].opcode == atsPkg::opSetClock);
      // set clock always enables, enable op carries the value in flag
      clkNext[s].enable = clkNext[s].load || side[s].flag;
      clkNext[s].rate   = {side[s].flag, side[s].rateLo};
      clkNext[s].count  = side[s].value;

      almNext[s]          = '0;
      almNext[s].valid    = accept[s] && isAlm[s];
      almNext[s].sel      = side[s].target;
      almNext[s].load     = (side[s].opcode != atsPkg::opEnAlarm);
      almNext[s].enable   = almNext[s].load || side[s].flag;
      almNext[s].loop     = (side[s].opcode == atsPkg::opSetAlarm) && side[s].flag;
      almNext[s].clockSel = side[s].clockSel;
      // timer deadline is interval plus current count, wraps at 16 bits
      if (side[s].opcode == atsPkg::opSetTimer) begin
        almNext[s].value = atsPkg::countT'(side[s].value + counts[side[s].clockSel]);
      end else begin
        almNext[s].value = side[s].value;
      end
    end
  end

  // one cycle to status and bank writes
  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      stat    <= 2'b00;
      clockWr <= '0;
      alarmWr <= '0;
    end else begin
      stat    <= accept;    // single pulse, valid never repeats back to back
      clockWr <= clkNext;
      alarmWr <= almNext;
    end
  end

endmodule

// ==== cmdCapture.sv ====
module cmdCapture (
  input  logic         clk_1x,
  input  logic         reset,
  input  logic         req,
  input  logic [15:0]  ctrl,
  output atsPkg::instrT instr,
  output logic         instrValid
);

  logic        pending;   // high half taken, low half due now
  logic [15:0] hiHalf;    // stored upper beat

  // beat tracking, a zero opcode never starts an instruction
  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      pending <= 1'b0;
    end else if (req && (ctrl[15:13] != 3'b000) && !pending) begin
      pending <= 1'b1;
    end else begin
      pending <= 1'b0;      // second beat consumed or idle
    end
  end

  // upper half of the instruction
  always_ff @(posedge clk_1x) begin
    if (req && (ctrl[15:13] != 3'b000) && !pending) begin
      hiHalf <= ctrl;
    end
  end

  // joined with the live low half, no extra latency
  assign instr      = atsPkg::instrT'({hiHalf, ctrl});
  assign instrValid = pending;

endmodule

// ==== compile.f ====
atsPkg.sv
cmdCapture.sv
cmdArbiter.sv
clockBank.sv
alarmBank.sv
timerTop.sv
timerTop_sva.sv
timerTop_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the timer unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module timerTop_tb -f compile.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/VtimerTop_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TESTBENCH PASSED"; then
  exit 0
fi
exit 1

// ==== timerTop.sv ====
module timerTop (
  input  logic        clk_1x,
  input  logic        reset,
  input  logic        req,
  input  logic [15:0] ctrlA,
  input  logic [15:0] ctrlB,
  output logic [1:0]  stat,   // bit 0 is client A
  output logic [23:0] data
);

  atsPkg::instrT                 instrA;
  atsPkg::instrT                 instrB;
  logic                          validA;
  logic                          validB;
  atsPkg::clockWriteT [1:0]      clockWr;
  atsPkg::alarmWriteT [1:0]      alarmWr;
  atsPkg::countArrayT            counts;
  logic [atsPkg::numClocks-1:0]  tick;

  ////////////////////////////////////////////////////////////////////////////
  // one assembler per client, both share req
  ////////////////////////////////////////////////////////////////////////////

  cmdCapture captureA (
    .clk_1x(clk_1x), .reset(reset), .req(req), .ctrl(ctrlA),
    .instr(instrA), .instrValid(validA)
  );

  cmdCapture captureB (
    .clk_1x(clk_1x), .reset(reset), .req(req), .ctrl(ctrlB),
    .instr(instrB), .instrValid(validB)
  );

  cmdArbiter arbiter (
    .clk_1x(clk_1x), .reset(reset),
    .instrA(instrA), .instrB(instrB), .validA(validA), .validB(validB),
    .counts(counts), .clockWr(clockWr), .alarmWr(alarmWr), .stat(stat)
  );

  clockBank clocks (
    .clk_1x(clk_1x), .reset(reset), .clockWr(clockWr),
    .counts(counts), .tick(tick)
  );

  alarmBank alarms (
    .clk_1x(clk_1x), .reset(reset), .alarmWr(alarmWr),
    .counts(counts), .tick(tick), .data(data)
  );

endmodule

// ==== timerTop_sva.sv ====
module statSva (
  input logic       clk_1x,
  input logic       reset,
  input logic [1:0] stat
);

  ////////////////////////////////////////////////////////////////////////////
  // status pulses
  ////////////////////////////////////////////////////////////////////////////

  // an ack or a refusal lasts one cycle only
  statOneCycle: assert property (@(posedge clk_1x) disable iff (reset)
    (stat != 2'b00) |=> (stat == 2'b00))
    else $error("stat high on two consecutive cycles");

  // no status while reset is held
  statQuietInReset: assert property (@(posedge clk_1x)
    reset |-> (stat == 2'b00))
    else $error("stat active during reset");

endmodule

module dataSva (
  input logic                         clk_1x,
  input logic                         reset,
  input logic [atsPkg::numAlarms-1:0] data
);

  ////////////////////////////////////////////////////////////////////////////
  // alarm pulses of two cycles each
  ////////////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < atsPkg::numAlarms; k++) begin : gData
    dataTwoCycles: assert property (@(posedge clk_1x) disable iff (reset)
      $rose(data[k]) |=> data[k] ##1 !data[k])
      else $error("data bit %0d high for other than two cycles", k);
  end

  // alarm outputs idle while reset is held
  dataQuietInReset: assert property (@(posedge clk_1x)
    reset |-> (data == '0))
    else $error("data active during reset");

endmodule

// status pulses come straight from the arbiter
bind cmdArbiter statSva arbSva (
  .clk_1x(clk_1x), .reset(reset), .stat(stat)
);

// firing pulses come straight from the alarm bank
bind alarmBank dataSva almSva (
  .clk_1x(clk_1x), .reset(reset), .data(data)
);

// ==== timerTop_tb.sv ====
module timerTop_tb;

  logic        clk_1x;
  logic        reset;
  logic        req;
  logic [15:0] ctrlA;
  logic [15:0] ctrlB;
  logic [1:0]  stat;
  logic [23:0] data;

  int mismatches;
  int timeouts;

  // reference state updated each rising edge
  atsPkg::countT      mCnt [atsPkg::numClocks];
  logic [15:0]        mEn;
  logic [1:0]         mRate [atsPkg::numClocks];
  logic [1:0]         mDiv;                       // prescaler
  logic [23:0]        aEn;
  logic [23:0]        aLoop;
  logic [3:0]         aClk [atsPkg::numAlarms];
  atsPkg::countT      aVal [atsPkg::numAlarms];
  int                 aFire [atsPkg::numAlarms];  // cycles of data still due
  atsPkg::clockWriteT mClkWr [2];
  atsPkg::alarmWriteT mAlmWr [2];
  logic [1:0]         expStat;
  logic               mPendA;
  logic               mPendB;
  logic [15:0]        mHiA;
  logic [15:0]        mHiB;
  logic [15:0]        lfsr;

  timerTop DUT (
    .clk_1x(clk_1x), .reset(reset), .req(req), .ctrlA(ctrlA), .ctrlB(ctrlB),
    .stat(stat), .data(data)
  );

  initial clk_1x = 1'b0;
  always #50 clk_1x = ~clk_1x;

  ////////////////////////////////////////////////////////////////////////////
  // random source and instruction building
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [15:0] lfsrNext(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // galois taps 16 14 13 11
  endfunction

  function automatic logic [15:0] takeBits(int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrNext(lfsr);   // one step per bit
      r[i] = lfsr[0];
    end
    return r;
  endfunction

  function automatic atsPkg::instrT mkInstr(atsPkg::opcodeT op, logic [4:0] tgt,
                                            logic flag, logic rateLo,
                                            logic [3:0] clkSel, atsPkg::countT value);
    atsPkg::instrT i;
    i = '0;
    i.opcode   = op;
    i.target   = tgt;
    i.flag     = flag;
    i.rateLo   = rateLo;
    i.clockSel = clkSel;
    i.value    = value;
    return i;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // reference rules
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic rateDue(logic [1:0] rate, logic [1:0] div);
    case (rate)
      atsPkg::rate1x:      return 1'b1;
      atsPkg::rateHalf:    return div[0];
      atsPkg::rateQuarter: return div == 2'b11;
      default:             return 1'b0;   // parked code
    endcase
  endfunction

  function automatic logic clockClass(atsPkg::instrT i);
    return (i.opcode == atsPkg::opSetClock) || (i.opcode == atsPkg::opEnClock);
  endfunction

  function automatic logic alarmClass(atsPkg::instrT i);
    return ((i.opcode == atsPkg::opSetAlarm) || (i.opcode == atsPkg::opSetTimer) ||
            (i.opcode == atsPkg::opEnAlarm)) && (i.target < 5'd24);
  endfunction

  // both refused on a shared target
  // alarm and timer count as one class
  function automatic logic [1:0] refAccept(atsPkg::instrT a, atsPkg::instrT b,
                                           logic va, logic vb);
    logic ca, cb, la, lb, same;
    ca   = va && clockClass(a);
    cb   = vb && clockClass(b);
    la   = va && alarmClass(a);
    lb   = vb && alarmClass(b);
    same = (ca && cb && (a.target[4:1] == b.target[4:1])) ||
           (la && lb && (a.target == b.target));
    if (same) return 2'b00;
    return {cb | lb, ca | la};
  endfunction

  function automatic atsPkg::clockWriteT clockCmd(atsPkg::instrT i, logic ok);
    atsPkg::clockWriteT c;
    c        = '0;
    c.valid  = ok && clockClass(i);
    c.sel    = i.target[4:1];
    c.load   = i.opcode == atsPkg::opSetClock;
    c.enable = c.load ? 1'b1 : i.flag;     // set clock starts it running
    c.rate   = {i.flag, i.rateLo};
    c.count  = i.value;
    return c;
  endfunction

  function automatic atsPkg::alarmWriteT alarmCmd(atsPkg::instrT i, logic ok);
    atsPkg::alarmWriteT a;
    a          = '0;
    a.valid    = ok && alarmClass(i);
    a.sel      = i.target;
    a.load     = i.opcode != atsPkg::opEnAlarm;
    a.enable   = a.load ? 1'b1 : i.flag;
    a.loop     = (i.opcode == atsPkg::opSetAlarm) && i.flag;
    a.clockSel = i.clockSel;
    a.value    = i.value;
    if (i.opcode == atsPkg::opSetTimer) begin
      a.value = atsPkg::countT'(i.value + mCnt[i.clockSel]);   // deadline wraps at 16 bits
    end
    return a;
  endfunction

  function automatic logic [23:0] expData();
    logic [23:0] d;
    for (int k = 0; k < atsPkg::numAlarms; k++) d[k] = aFire[k] != 0;
    return d;
  endfunction

  // cycle model of capture, arbiter and both banks
  always @(posedge clk_1x or posedge reset) begin
    logic [15:0]        tickV;
    logic [1:0]         acc;
    logic               hit;
    atsPkg::instrT      ia;
    atsPkg::instrT      ib;
    atsPkg::clockWriteT nc [2];
    atsPkg::alarmWriteT na [2];
    if (reset) begin
      mDiv    = 2'b00;
      mEn     = '0;
      aEn     = '0;
      aLoop   = '0;
      expStat = 2'b00;
      mPendA  = 1'b0;
      mPendB  = 1'b0;
      for (int w = 0; w < 2; w++) begin
        mClkWr[w] = '0;
        mAlmWr[w] = '0;
      end
      for (int i = 0; i < atsPkg::numClocks; i++) begin
        mCnt[i]  = '0;
        mRate[i] = atsPkg::rate1x;
      end
      for (int k = 0; k < atsPkg::numAlarms; k++) begin
        aFire[k] = 0;
        aClk[k]  = '0;
        aVal[k]  = '0;
      end
    end else begin
      for (int i = 0; i < atsPkg::numClocks; i++) begin
        hit = 1'b0;
        for (int w = 0; w < 2; w++) begin
          if (mClkWr[w].valid && mClkWr[w].load && (mClkWr[w].sel == 4'(i))) hit = 1'b1;
        end
        tickV[i] = mEn[i] && rateDue(mRate[i], mDiv) && !hit;   // reload is no advance
      end
      for (int k = 0; k < atsPkg::numAlarms; k++) begin
        hit = 1'b0;
        for (int w = 0; w < 2; w++) begin
          if (mAlmWr[w].valid && (mAlmWr[w].sel == 5'(k))) hit = 1'b1;
        end
        if (aEn[k] && tickV[aClk[k]] && !hit &&
            (atsPkg::countT'(mCnt[aClk[k]] + 16'd1) == aVal[k])) begin
          aFire[k] = 2;
          if (!aLoop[k]) aEn[k] = 1'b0;
        end else if (aFire[k] > 0) begin
          aFire[k] = aFire[k] - 1;
        end
      end
      for (int w = 0; w < 2; w++) begin
        if (mAlmWr[w].valid) begin
          aEn[mAlmWr[w].sel] = mAlmWr[w].enable;
          if (mAlmWr[w].load) begin
            aLoop[mAlmWr[w].sel] = mAlmWr[w].loop;
            aClk[mAlmWr[w].sel]  = mAlmWr[w].clockSel;
            aVal[mAlmWr[w].sel]  = mAlmWr[w].value;
          end
        end
      end
      // arbiter sees counts before this edge's increments
      ia    = atsPkg::instrT'({mHiA, ctrlA});
      ib    = atsPkg::instrT'({mHiB, ctrlB});
      acc   = refAccept(ia, ib, mPendA, mPendB);
      nc[0] = clockCmd(ia, acc[0]);
      nc[1] = clockCmd(ib, acc[1]);
      na[0] = alarmCmd(ia, acc[0]);
      na[1] = alarmCmd(ib, acc[1]);
      for (int i = 0; i < atsPkg::numClocks; i++) begin
        if (tickV[i]) mCnt[i] = mCnt[i] + 16'd1;
      end
      for (int w = 0; w < 2; w++) begin
        if (mClkWr[w].valid) begin
          mEn[mClkWr[w].sel] = mClkWr[w].enable;
          if (mClkWr[w].load) begin
            mCnt[mClkWr[w].sel]  = mClkWr[w].count;
            mRate[mClkWr[w].sel] = mClkWr[w].rate;
          end
        end
      end
      mDiv    = mDiv + 2'd1;
      mClkWr  = nc;
      mAlmWr  = na;
      expStat = acc;
      // two-beat capture where a zero opcode never starts
      if (req && (ctrlA[15:13] != 3'b000) && !mPendA) begin
        mPendA = 1'b1;
        mHiA   = ctrlA;
      end else begin
        mPendA = 1'b0;
      end
      if (req && (ctrlB[15:13] != 3'b000) && !mPendB) begin
        mPendB = 1'b1;
        mHiB   = ctrlB;
      end else begin
        mPendB = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // compare
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkStat(input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      $display("Mismatch stat got %h expected %h at %0t", got, exp, $time);
      mismatches++;
    end
  endtask

  task automatic checkData(input logic [atsPkg::numAlarms-1:0] got,
                           input logic [atsPkg::numAlarms-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch data got %h expected %h at %0t", got, exp, $time);
      mismatches++;
    end
  endtask

  always @(negedge clk_1x) begin
    if (!reset) begin     // outputs settled mid-cycle
      checkStat(stat, expStat);
      checkData(data, expData());
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic issue(input atsPkg::instrT a, input atsPkg::instrT b);
    @(posedge clk_1x);
    #10;
    req   = 1'b1;
    ctrlA = a[31:16];
    ctrlB = b[31:16];
    @(posedge clk_1x);
    #10;
    req   = 1'b0;
    ctrlA = a[15:0];
    ctrlB = b[15:0];
    @(posedge clk_1x);
    #10;
    ctrlA = '0;
    ctrlB = '0;
    repeat (2) @(posedge clk_1x);   // stat and bank write have landed
  endtask

  task automatic waitAlarm(input logic [4:0] k, input int limit);
    bit seen;
    seen = 0;
    for (int n = 0; n < limit && !seen; n++) begin
      @(negedge clk_1x);
      if (data[k]) seen = 1;
    end
    if (!seen) begin
      $display("alarm %0d did not fire within %0d cycles", k, limit);
      timeouts++;
    end
  endtask

  task automatic expectQuiet(input logic [4:0] k, input int cycles);
    for (int n = 0; n < cycles; n++) begin
      @(negedge clk_1x);
      if (data[k]) begin
        $display("Mismatch data[%0d] got %h expected %h at %0t", k, data[k], 1'b0, $time);
        mismatches++;
      end
    end
  endtask

  initial begin
    #(100 * 8000);
    $display("simulation ran out of time");
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    atsPkg::instrT nop;
    logic [3:0]    c0;
    logic [4:0]    s0;
    logic [4:0]    s [8];
    nop        = '0;
    mismatches = 0;
    timeouts   = 0;
    lfsr       = 16'd92;
    reset      = 1'b1;
    req        = 1'b0;
    ctrlA      = '0;
    ctrlB      = '0;
    repeat (16) @(posedge clk_1x);
    #10;
    reset = 1'b0;

    c0 = 4'(takeBits(4));
    s0 = 5'(takeBits(5) % 24);
    for (int k = 0; k < 8; k++) s[k] = 5'((s0 + k) % 24);

    // single client one-shot at rate1x
    issue(mkInstr(atsPkg::opSetClock, {c0, 1'b0}, 1'b0, 1'b0, 4'd0, 16'd100), nop);
    issue(mkInstr(atsPkg::opSetAlarm, s[0], 1'b0, 1'b0, c0, 16'd120 + takeBits(3)), nop);
    waitAlarm(s[0], 80);
    repeat (30) @(posedge clk_1x);

    // half rate with a repeating alarm across the wrap
    issue(mkInstr(atsPkg::opSetClock, {c0 + 4'd1, 1'b0}, 1'b0, 1'b1, 4'd0, 16'hFFF8), nop);
    issue(mkInstr(atsPkg::opSetAlarm, s[1], 1'b1, 1'b0, c0 + 4'd1, 16'h0002), nop);
    waitAlarm(s[1], 100);
    issue(mkInstr(atsPkg::opSetClock, {c0 + 4'd1, 1'b0}, 1'b0, 1'b1, 4'd0, 16'hFFFC), nop);
    waitAlarm(s[1], 100);   // loop bit keeps it armed
    // quarter rate
    issue(mkInstr(atsPkg::opSetClock, {c0 + 4'd2, 1'b0}, 1'b1, 1'b0, 4'd0, 16'd500), nop);
    issue(mkInstr(atsPkg::opSetAlarm, s[2], 1'b0, 1'b0, c0 + 4'd2, 16'd510), nop);
    waitAlarm(s[2], 120);

    // countdown on the rate1x clock
    issue(mkInstr(atsPkg::opSetTimer, s[3], 1'b0, 1'b0, c0, 16'd30 + takeBits(4)), nop);
    waitAlarm(s[3], 120);

    // conflicts on the same clock then alarm against timer
    issue(mkInstr(atsPkg::opSetClock, {c0, 1'b0}, 1'b0, 1'b0, 4'd0, 16'd7),
          mkInstr(atsPkg::opEnClock, {c0, 1'b0}, 1'b0, 1'b0, 4'd0, 16'd0));
    issue(mkInstr(atsPkg::opSetAlarm, s[4], 1'b0, 1'b0, c0, 16'd9),
          mkInstr(atsPkg::opSetTimer, s[4], 1'b0, 1'b0, c0, 16'd9));
    // both acked on different targets
    issue(mkInstr(atsPkg::opSetClock, {c0 + 4'd3, 1'b0}, 1'b0, 1'b0, 4'd0, 16'd200),
          mkInstr(atsPkg::opSetAlarm, s[5], 1'b0, 1'b0, c0 + 4'd3, 16'd230));
    waitAlarm(s[5], 80);

    // frozen clock keeps its alarm silent
    issue(mkInstr(atsPkg::opSetClock, {c0 + 4'd4, 1'b0}, 1'b0, 1'b0, 4'd0, 16'd0), nop);
    issue(mkInstr(atsPkg::opSetAlarm, s[6], 1'b0, 1'b0, c0 + 4'd4, 16'd40), nop);
    issue(mkInstr(atsPkg::opEnClock, {c0 + 4'd4, 1'b0}, 1'b0, 1'b0, 4'd0, 16'd0), nop);
    expectQuiet(s[6], 80);
    // disabled alarm stays silent
    issue(mkInstr(atsPkg::opSetAlarm, s[7], 1'b0, 1'b0, c0, mCnt[c0] + 16'd40), nop);
    issue(mkInstr(atsPkg::opEnAlarm, s[7], 1'b0, 1'b0, 4'd0, 16'd0), nop);
    expectQuiet(s[7], 80);
    // mode and nop are refused
    issue(mkInstr(atsPkg::opMode, 5'd0, 1'b1, 1'b1, 4'd0, 16'hFFFF), nop);
    issue(mkInstr(atsPkg::opNop, 5'd2, 1'b1, 1'b0, 4'd0, 16'd5), nop);
    repeat (10) @(posedge clk_1x);

    $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if ((mismatches + timeouts) == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
